// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rp_top_tb
FILELIST  = rp_top.f
OBJ_DIR   = obj_dir
PASS_TEXT = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/adc_frontend.sv ====
`timescale 1ns/1ps

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::adc_code_t adc_dat_a_i,     // raw CH1, negative slope
  input  rp_pkg::adc_code_t adc_dat_b_i,     // raw CH2
  input  logic              digital_loop_i,  // from housekeeping
  input  rp_pkg::sample_t   loop_a_i,        // DAC side sample A
  input  rp_pkg::sample_t   loop_b_i,        // DAC side sample B
  output rp_pkg::sample_t   adc_a_o,
  output rp_pkg::sample_t   adc_b_o
);

  rp_pkg::adc_code_t adc_dat_a, adc_dat_b;  // input registers
  rp_pkg::sample_t   conv_a, conv_b;

  //////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////

  // start from the code of a zero sample
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_dat_a <= rp_pkg::ZERO_CODE;
      adc_dat_b <= rp_pkg::ZERO_CODE;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i;
      adc_dat_b <= adc_dat_b_i;
    end
  end

  // negative slope offset code -> two's complement
  assign conv_a = {adc_dat_a[14-1], ~adc_dat_a[14-2:0]};
  assign conv_b = {adc_dat_b[14-1], ~adc_dat_b[14-2:0]};

  // loopback swaps in the DAC samples
  assign adc_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

// ==== logic/dac_backend.sv ====
`timescale 1ns/1ps

module dac_backend (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::sample_t   dac_a_i,    // CH1, two's complement
  input  rp_pkg::sample_t   dac_b_i,    // CH2
  output rp_pkg::adc_code_t dac_dat_o,  // shared pin bus
  output logic              dac_sel_o
);

  rp_pkg::adc_code_t  dac_dat_a, dac_dat_b;  // converted, one per channel
  rp_pkg::adc_code_t  dac_dat;               // interleaved output register
  rp_pkg::dac_phase_e phase;

  //////////////////////////////////////////////////
  // output registers, back to offset coding
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a <= rp_pkg::ZERO_CODE;
      dac_dat_b <= rp_pkg::ZERO_CODE;
    end
    else
    begin
      dac_dat_a <= {dac_a_i[14-1], ~dac_a_i[14-2:0]};  // keep msb, flip rest
      dac_dat_b <= {dac_b_i[14-1], ~dac_b_i[14-2:0]};
    end
  end

  //////////////////////////////////////////////////
  // two phase interleave
  //////////////////////////////////////////////////

  // load the channel of the coming phase, so data and sel line up
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      phase   <= rp_pkg::PHASE_A;
      dac_dat <= rp_pkg::ZERO_CODE;
    end
    else
    begin
      phase   <= (phase == rp_pkg::PHASE_A) ? rp_pkg::PHASE_B : rp_pkg::PHASE_A;
      dac_dat <= (phase == rp_pkg::PHASE_B) ? dac_dat_a : dac_dat_b;
    end
  end

  assign dac_dat_o = dac_dat;
  assign dac_sel_o = (phase == rp_pkg::PHASE_B);  // high while B shows

endmodule

// ==== logic/housekeeping.sv ====
`timescale 1ns/1ps

module housekeeping #(
  parameter int LED_W = 8
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,       // already gated to region 0
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              digital_loop_o,  // ADC <- DAC loopback
  output logic [LED_W-1:0]  led_o
);

  logic [rp_pkg::REGION_LSB-1:0] offset;  // offset inside the region
  logic                          digital_loop;
  logic [LED_W-1:0]              led;
  rp_pkg::bus_data_t             rdata;
  logic                          ack;

  assign offset = sys_addr_i[rp_pkg::REGION_LSB-1:0];

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop <= 1'b0;
      led          <= '0;
    end
    else if (sys_wen_i)
    begin
      case (offset)
        rp_pkg::HK_DIGITAL_LOOP_ADDR : digital_loop <= sys_wdata_i[0];
        rp_pkg::HK_LED_ADDR          : led          <= sys_wdata_i[LED_W-1:0];
        default                      : ;  // unknown offset, ignored
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read back and acknowledge
  //////////////////////////////////////////////////

  // every enable answered one cycle later
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack <= 1'b0;
    else
      ack <= sys_wen_i | sys_ren_i;
  end

  // only meaningful in the ack cycle
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (offset)
        rp_pkg::HK_ID_ADDR           : rdata <= rp_pkg::HK_ID;
        rp_pkg::HK_DIGITAL_LOOP_ADDR : rdata <= rp_pkg::bus_data_t'(digital_loop);
        rp_pkg::HK_LED_ADDR          : rdata <= rp_pkg::bus_data_t'(led);
        default                      : rdata <= '0;
      endcase
    end
  end

  assign sys_rdata_o    = rdata;
  assign sys_ack_o      = ack;
  assign digital_loop_o = digital_loop;
  assign led_o          = led;

endmodule

// ==== logic/output_source_regs.sv ====
`timescale 1ns/1ps

module output_source_regs (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,   // already gated to region 1
  input  logic              sys_ren_i,
  input  rp_pkg::sample_t   adc_a_i,
  input  rp_pkg::sample_t   adc_b_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output rp_pkg::sample_t   out_a_o,     // to DAC CH1
  output rp_pkg::sample_t   out_b_o      // to DAC CH2
);

  localparam int EXT_W = $bits(rp_pkg::bus_data_t) - $bits(rp_pkg::sample_t);

  logic [rp_pkg::REGION_LSB-1:0] offset;
  logic [2-1:0]                  src_sel;   // [0] A, [1] B; 1 picks the constant
  rp_pkg::sample_t               const_a, const_b;
  rp_pkg::bus_data_t             rdata;
  logic                          ack;

  assign offset = sys_addr_i[rp_pkg::REGION_LSB-1:0];

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      src_sel <= 2'b00;  // both on ADC
      const_a <= '0;
      const_b <= '0;
    end
    else if (sys_wen_i)
    begin
      case (offset)
        rp_pkg::SRC_SEL_ADDR     : src_sel <= sys_wdata_i[2-1:0];
        rp_pkg::SRC_CONST_A_ADDR : const_a <= sys_wdata_i[14-1:0];  // low 14 bits
        rp_pkg::SRC_CONST_B_ADDR : const_b <= sys_wdata_i[14-1:0];
        default                  : ;
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack <= 1'b0;
    else
      ack <= sys_wen_i | sys_ren_i;
  end

  // constants come back sign extended
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (offset)
        rp_pkg::SRC_SEL_ADDR     : rdata <= rp_pkg::bus_data_t'(src_sel);
        rp_pkg::SRC_CONST_A_ADDR : rdata <= {{EXT_W{const_a[14-1]}}, const_a};
        rp_pkg::SRC_CONST_B_ADDR : rdata <= {{EXT_W{const_b[14-1]}}, const_b};
        default                  : rdata <= '0;
      endcase
    end
  end

  assign sys_rdata_o = rdata;
  assign sys_ack_o   = ack;

  // source mux, stands in for the DSP / generator
  assign out_a_o = src_sel[0] ? const_a : adc_a_i;
  assign out_b_o = src_sel[1] ? const_b : adc_b_i;

endmodule

// ==== logic/rp_pkg.sv ====
package rp_pkg;

  //////////////////////////////////////////////////
  // sample and bus types
  //////////////////////////////////////////////////

  typedef logic signed [14-1:0] sample_t;   // two's complement channel sample
  typedef logic        [14-1:0] adc_code_t; // raw converter code, negative slope
  typedef logic        [32-1:0] bus_addr_t;
  typedef logic        [32-1:0] bus_data_t;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  localparam int N_REGIONS  = 8;  // regions behind the decoder
  localparam int REGION_LSB = 20; // region index sits on addr[22:20]
  localparam int REGION_W   = 3;

  // region 0, housekeeping
  localparam bus_data_t                 HK_ID                = 32'h5250_0001;
  localparam logic [REGION_LSB-1:0]     HK_ID_ADDR           = 20'h00000;
  localparam logic [REGION_LSB-1:0]     HK_DIGITAL_LOOP_ADDR = 20'h00004;
  localparam logic [REGION_LSB-1:0]     HK_LED_ADDR          = 20'h00030;

  // region 1, output source registers
  localparam logic [REGION_LSB-1:0]     SRC_SEL_ADDR         = 20'h00000;
  localparam logic [REGION_LSB-1:0]     SRC_CONST_A_ADDR     = 20'h00004;
  localparam logic [REGION_LSB-1:0]     SRC_CONST_B_ADDR     = 20'h00008;

  //////////////////////////////////////////////////
  // converter side
  //////////////////////////////////////////////////

  // code that stands for a zero sample on both converters
  // top bit kept, lower 13 inverted
  localparam adc_code_t ZERO_CODE = 14'h1fff;

  // DAC interleave, one channel per cycle
  typedef enum logic {
    PHASE_A = 1'b0, // sel low, channel A on the bus
    PHASE_B = 1'b1  // sel high, channel B on the bus
  } dac_phase_e;

endpackage

// ==== logic/rp_top.sv ====
`timescale 1ns/1ps

module rp_top #(
  parameter int LED_W = 8
) (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  // ADC pins
  input  rp_pkg::adc_code_t   adc_dat_a_i,  // CH1 raw
  input  rp_pkg::adc_code_t   adc_dat_b_i,  // CH2 raw
  // system bus
  input  rp_pkg::bus_addr_t   sys_addr_i,
  input  rp_pkg::bus_data_t   sys_wdata_i,
  input  logic                sys_wen_i,    // single cycle pulse
  input  logic                sys_ren_i,    // single cycle pulse
  output rp_pkg::bus_data_t   sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  // DAC pins
  output rp_pkg::adc_code_t   dac_dat_o,    // interleaved A/B
  output logic                dac_sel_o,    // high while B is on the bus
  // LEDs
  output logic [LED_W-1:0]    led_o
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // per region bus slices
  logic              hk_wen, hk_ren, hk_ack;
  logic              src_wen, src_ren, src_ack;
  rp_pkg::bus_data_t hk_rdata, src_rdata;

  // sample path
  rp_pkg::sample_t   adc_a, adc_b;  // after conversion / loopback
  rp_pkg::sample_t   out_a, out_b;  // to DAC, also loopback source

  logic              digital_loop;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .hk_rdata_i   (hk_rdata),
    .hk_ack_i     (hk_ack),
    .src_rdata_i  (src_rdata),
    .src_ack_i    (src_ack),
    .hk_wen_o     (hk_wen),
    .hk_ren_o     (hk_ren),
    .src_wen_o    (src_wen),
    .src_ren_o    (src_ren),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o)
  );

  housekeeping #(
    .LED_W (LED_W)
  ) i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (hk_wen),       // region 0
    .sys_ren_i      (hk_ren),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  output_source_regs i_src (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_wen_i    (src_wen),        // region 1
    .sys_ren_i    (src_ren),
    .adc_a_i      (adc_a),
    .adc_b_i      (adc_b),
    .sys_rdata_o  (src_rdata),
    .sys_ack_o    (src_ack),
    .out_a_o      (out_a),
    .out_b_o      (out_b)
  );

  //////////////////////////////////////////////////
  // analog front and back end
  //////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (out_a),        // DAC samples fed back
    .loop_b_i       (out_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_backend i_dac (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .dac_a_i    (out_a),
    .dac_b_i    (out_b),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

endmodule

// ==== logic/sys_bus_decoder.sv ====
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  input  rp_pkg::bus_data_t hk_rdata_i,   // region 0
  input  logic              hk_ack_i,
  input  rp_pkg::bus_data_t src_rdata_i,  // region 1
  input  logic              src_ack_i,
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  output logic              src_wen_o,
  output logic              src_ren_o,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o
);

  localparam int N = rp_pkg::N_REGIONS;

  logic [rp_pkg::REGION_W-1:0] region;       // live index from the address
  logic [rp_pkg::REGION_W-1:0] region_q;     // index of the pending access
  logic [rp_pkg::REGION_W-1:0] resp_region;  // region that answers this cycle
  logic [N-1:0]                sys_cs, resp_cs;
  logic [N-1:0]                sys_wen, sys_ren;
  logic [N-1:0]                sys_ack;
  rp_pkg::bus_data_t           sys_rdata [N];
  logic                        pulse;

  assign region = sys_addr_i[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign pulse  = sys_wen_i | sys_ren_i;

  // one-hot chip select, gates both enables
  assign sys_cs  = {{(N-1){1'b0}}, 1'b1} << region;
  assign sys_wen = sys_cs & {N{sys_wen_i}};
  assign sys_ren = sys_cs & {N{sys_ren_i}};

  assign hk_wen_o  = sys_wen[0];
  assign hk_ren_o  = sys_ren[0];
  assign src_wen_o = sys_wen[1];
  assign src_ren_o = sys_ren[1];

  // remember who was addressed, the slow slaves answer a cycle later
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      region_q <= '0;
    else if (pulse)
      region_q <= region;
  end

  assign resp_region = pulse ? region : region_q;
  assign resp_cs     = {{(N-1){1'b0}}, 1'b1} << resp_region;

  // gather slave responses
  always_comb
  begin
    sys_rdata[0] = hk_rdata_i;
    sys_ack[0]   = hk_ack_i;
    sys_rdata[1] = src_rdata_i;
    sys_ack[1]   = src_ack_i;
    for (int r = 2; r < N; r++)
    begin
      sys_rdata[r] = '0;                       // unused region, reads zero
      sys_ack[r]   = sys_wen[r] | sys_ren[r];  // answers at once
    end
  end

  assign sys_rdata_o = sys_rdata[resp_region];
  assign sys_ack_o   = |(resp_cs & sys_ack);
  assign sys_err_o   = 1'b0;  // no slave flags errors here

endmodule

// ==== rp_top.f ====
logic/rp_pkg.sv
logic/sys_bus_decoder.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/housekeeping.sv
logic/output_source_regs.sv
logic/rp_top.sv
verification/rp_top_props.sv
verification/rp_top_tb.sv

// ==== verification/rp_top_props.sv ====
`timescale 1ns/1ps

module rp_top_props (
  input logic adc_clk,
  input logic rst_n_i,
  input logic wen_i,      // bus write pulse
  input logic ren_i,      // bus read pulse
  input logic ack_i,
  input logic dac_sel_i
);

  //////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////

  // ack only in the pulse cycle or the one after
  ack_follows_enable_a : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    $rose(ack_i) |-> (wen_i || ren_i || $past(wen_i || ren_i))
  ) else $error("sys_ack_o rose with no bus enable in this or the previous cycle");

  // one answer per pulse, never stretched
  ack_single_cycle_a : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |=> !ack_i
  ) else $error("sys_ack_o stayed high for more than one cycle");

  //////////////////////////////////////////////////
  // DAC interleave
  //////////////////////////////////////////////////

  // first edge after reset release is skipped
  dac_sel_toggles_a : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (dac_sel_i != $past(dac_sel_i))
  ) else $error("dac_sel_o failed to toggle");

endmodule

bind rp_top rp_top_props props0 (
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .wen_i     (sys_wen_i),
  .ren_i     (sys_ren_i),
  .ack_i     (sys_ack_o),
  .dac_sel_i (dac_sel_o)
);

// ==== verification/rp_top_tb.sv ====
`timescale 1ns/1ps

module rp_top_tb;

  localparam int PERIOD      = 100;
  localparam int ACK_TIMEOUT = 20;   // cycles
  localparam int N_ENTRIES   = 8;
  localparam int LED_W       = 8;

  logic                adc_clk;
  logic                rst_n_i;
  rp_pkg::adc_code_t   adc_dat_a_i, adc_dat_b_i;
  rp_pkg::bus_addr_t   sys_addr_i;
  rp_pkg::bus_data_t   sys_wdata_i;
  logic                sys_wen_i, sys_ren_i;
  rp_pkg::bus_data_t   sys_rdata_o;
  logic                sys_ack_o, sys_err_o;
  rp_pkg::adc_code_t   dac_dat_o;
  logic                dac_sel_o;
  logic [LED_W-1:0]    led_o;

  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  integer seed = 96444;

  // stimulus table, one row per entry
  rp_pkg::adc_code_t tab_raw_a [N_ENTRIES];
  rp_pkg::adc_code_t tab_raw_b [N_ENTRIES];
  logic [1:0]        tab_sel [N_ENTRIES];     // [0] A, [1] B on the constant
  rp_pkg::sample_t   tab_const_a [N_ENTRIES];
  rp_pkg::sample_t   tab_const_b [N_ENTRIES];
  logic              tab_loop [N_ENTRIES];
  rp_pkg::adc_code_t tab_exp_a [N_ENTRIES];
  rp_pkg::adc_code_t tab_exp_b [N_ENTRIES];

  rp_top #(.LED_W(LED_W)) dut0 (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #(PERIOD/2) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // negative slope code falls one step per sample step from 0x1fff at zero
  function automatic rp_pkg::adc_code_t offset_code(input rp_pkg::sample_t s);
    return rp_pkg::adc_code_t'(14'h1fff - s);
  endfunction

  function automatic rp_pkg::bus_addr_t region_addr(input int r, input logic [19:0] off);
    return (rp_pkg::bus_addr_t'(r) << rp_pkg::REGION_LSB) | rp_pkg::bus_addr_t'(off);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors != errs_at_start)
    begin
      tests_failed++;
      $display("test %0d %s: fail", tests_run, name);
    end
    else
      $display("test %0d %s: pass", tests_run, name);
  endtask

  // one pulse, then poll for ack a little after each falling edge
  task automatic bus_access(input bit write, input rp_pkg::bus_addr_t addr,
                            input rp_pkg::bus_data_t wdata,
                            output rp_pkg::bus_data_t rdata);
    bit got;
    int n;
    got   = 1'b0;
    n     = 0;
    rdata = '0;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = write;
    sys_ren_i   = !write;
    while (!got && n < ACK_TIMEOUT)
    begin
      #(PERIOD/10);  // away from both edges
      if (sys_ack_o)
      begin
        got   = 1'b1;
        rdata = sys_rdata_o;
        if (sys_err_o !== 1'b0) report_mismatch("sys_err_o", 32'(sys_err_o), 32'h0);
      end
      @(negedge adc_clk);
      sys_wen_i = 1'b0;  // pulse lasts one cycle
      sys_ren_i = 1'b0;
      n++;
    end
    if (!got)
    begin
      $display("bus timeout: no acknowledge for address %h within %0d cycles",
               addr, ACK_TIMEOUT);
      errors++;
    end
  endtask

  task automatic bus_write(input rp_pkg::bus_addr_t addr, input rp_pkg::bus_data_t data);
    rp_pkg::bus_data_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_and_compare(input string name, input rp_pkg::bus_addr_t addr,
                                  input rp_pkg::bus_data_t exp);
    rp_pkg::bus_data_t d;
    bus_access(1'b0, addr, '0, d);
    if (d !== exp) report_mismatch(name, d, exp);
  endtask

  // grab one A and one B word off the shared DAC bus
  task automatic read_dac(output rp_pkg::adc_code_t a, output rp_pkg::adc_code_t b,
                          output bit ok);
    bit got_a, got_b;
    int n;
    got_a = 1'b0;
    got_b = 1'b0;
    n     = 0;
    while (!(got_a && got_b) && n < 8)
    begin
      @(negedge adc_clk);
      if (dac_sel_o)
      begin
        b     = dac_dat_o;
        got_b = 1'b1;
      end
      else
      begin
        a     = dac_dat_o;
        got_a = 1'b1;
      end
      n++;
    end
    ok = got_a && got_b;
    if (!ok) $display("dac_sel_o did not show both phases within 8 cycles");
  endtask

  task automatic build_table();
    rp_pkg::adc_code_t prev_a, prev_b;
    prev_a = offset_code('0);
    prev_b = offset_code('0);
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      tab_raw_a[i] = rp_pkg::adc_code_t'($random(seed));
      tab_raw_b[i] = rp_pkg::adc_code_t'($random(seed));
    end
    tab_sel     = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd0};
    tab_const_a = '{14'h0, 14'h0, 14'h0, 14'h0abc, 14'h0, 14'h2001, 14'h2001, 14'h0};
    tab_const_b = '{14'h0, 14'h0, 14'h0, 14'h0, 14'h3c18, 14'h1555, 14'h1555, 14'h0};
    tab_loop    = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    // constant wins, else loopback holds the last code, else raw passes through
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      if (tab_sel[i][0])
        tab_exp_a[i] = offset_code(tab_const_a[i]);
      else if (tab_loop[i])
        tab_exp_a[i] = prev_a;
      else
        tab_exp_a[i] = tab_raw_a[i];
      if (tab_sel[i][1])
        tab_exp_b[i] = offset_code(tab_const_b[i]);
      else if (tab_loop[i])
        tab_exp_b[i] = prev_b;
      else
        tab_exp_b[i] = tab_raw_b[i];
      prev_a = tab_exp_a[i];
      prev_b = tab_exp_b[i];
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    rp_pkg::adc_code_t da, db;
    bit                ok;
    int                start;
    rst_n_i     = 1'b0;
    adc_dat_a_i = offset_code('0);  // idle at a zero sample
    adc_dat_b_i = offset_code('0);
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    build_table();
    start = errors;
    repeat (3) @(negedge adc_clk);
    // still in reset, interleave parked on channel A
    if (dac_sel_o !== 1'b0) report_mismatch("dac_sel_o", 32'(dac_sel_o), 32'h0);
    if (dac_dat_o !== offset_code('0))
      report_mismatch("dac_dat_o", 32'(dac_dat_o), 32'(offset_code('0)));
    if (sys_ack_o !== 1'b0) report_mismatch("sys_ack_o", 32'(sys_ack_o), 32'h0);
    rst_n_i = 1'b1;

    // reset state
    if (led_o !== '0) report_mismatch("led_o", 32'(led_o), 32'h0);
    read_and_compare("hk id", region_addr(0, 20'h0), rp_pkg::HK_ID);
    read_dac(da, db, ok);
    if (!ok) errors++;
    if (da !== offset_code('0)) report_mismatch("dac_dat_o A", 32'(da), 32'(offset_code('0)));
    if (db !== offset_code('0)) report_mismatch("dac_dat_o B", 32'(db), 32'(offset_code('0)));
    end_test("reset state", start);

    // register read back, regions 0 and 1
    start = errors;
    bus_write(region_addr(0, rp_pkg::HK_LED_ADDR), 32'h0000_00a5);
    read_and_compare("hk led", region_addr(0, rp_pkg::HK_LED_ADDR), 32'h0000_00a5);
    if (led_o !== 8'ha5) report_mismatch("led_o", 32'(led_o), 32'h0000_00a5);
    bus_write(region_addr(0, rp_pkg::HK_DIGITAL_LOOP_ADDR), 32'h1);
    read_and_compare("hk loop", region_addr(0, rp_pkg::HK_DIGITAL_LOOP_ADDR), 32'h1);
    bus_write(region_addr(0, rp_pkg::HK_DIGITAL_LOOP_ADDR), 32'h0);
    bus_write(region_addr(1, rp_pkg::SRC_SEL_ADDR), 32'h3);
    read_and_compare("src sel", region_addr(1, rp_pkg::SRC_SEL_ADDR), 32'h3);
    bus_write(region_addr(1, rp_pkg::SRC_CONST_A_ADDR), 32'h0000_2abc);
    read_and_compare("const a", region_addr(1, rp_pkg::SRC_CONST_A_ADDR), 32'hffff_eabc);
    bus_write(region_addr(1, rp_pkg::SRC_CONST_B_ADDR), 32'h0000_0123);
    read_and_compare("const b", region_addr(1, rp_pkg::SRC_CONST_B_ADDR), 32'h0000_0123);
    read_and_compare("hk unknown", region_addr(0, 20'h00010), 32'h0);
    read_and_compare("src unknown", region_addr(1, 20'h00020), 32'h0);
    end_test("register access", start);

    // empty regions answer at once with zero
    start = errors;
    for (int r = 2; r < rp_pkg::N_REGIONS; r++)
    begin
      bus_write(region_addr(r, 20'h00004), 32'hdead_beef);
      read_and_compare($sformatf("region %0d", r), region_addr(r, 20'h00004), 32'h0);
    end
    end_test("empty regions", start);

    // sample path table
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      start = errors;
      @(negedge adc_clk);
      adc_dat_a_i = tab_raw_a[i];
      adc_dat_b_i = tab_raw_b[i];
      bus_write(region_addr(1, rp_pkg::SRC_CONST_A_ADDR), rp_pkg::bus_data_t'(tab_const_a[i]));
      bus_write(region_addr(1, rp_pkg::SRC_CONST_B_ADDR), rp_pkg::bus_data_t'(tab_const_b[i]));
      bus_write(region_addr(0, rp_pkg::HK_DIGITAL_LOOP_ADDR), 32'(tab_loop[i]));
      bus_write(region_addr(1, rp_pkg::SRC_SEL_ADDR), 32'(tab_sel[i]));
      for (int k = 0; k < 8; k++)
        @(negedge adc_clk);  // pipeline settle
      read_dac(da, db, ok);
      if (!ok) errors++;
      if (da !== tab_exp_a[i]) report_mismatch("dac_dat_o A", 32'(da), 32'(tab_exp_a[i]));
      if (db !== tab_exp_b[i]) report_mismatch("dac_dat_o B", 32'(db), 32'(tab_exp_b[i]));
      end_test($sformatf("table entry %0d", i), start);
    end

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
